/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove obj_dir and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_mcr3_input
	./obj_dir/Vtb_mcr3_input +verilator+error+limit+100 > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

/* hw/gear_shifter.sv */
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

// Power Drive low/high gear, one toggle per player on fire D
module gear_shifter (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic [`MCR3_NUM_PLAYERS-1:0] fire_d,
	output logic [`MCR3_NUM_PLAYERS-1:0] gear
);

	logic [`MCR3_NUM_PLAYERS-1:0] fire_d_q;
	logic [`MCR3_NUM_PLAYERS-1:0] fire_d_rise;

	// Press edge only, holding the button does nothing more
	assign fire_d_rise = fire_d & ~fire_d_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fire_d_q <= '0;
			gear     <= '0;
		end else begin
			fire_d_q <= fire_d;
			// Runs in every game, only Power Drive reads it
			gear     <= gear ^ fire_d_rise;
		end
	end

endmodule

/* hw/input_config_regs.sv */
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

module input_config_regs (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [`MCR3_ADR_W-1:0]  wb_adr,
	input  logic [`MCR3_PORT_W-1:0] wb_dat_w,
	output logic [`MCR3_PORT_W-1:0] wb_dat_r,
	output logic                    wb_ack,
	mcr3_cfg_if.cfg_src             cfg
);
	import mcr3_input_pkg::*;

	logic                    wb_open;
	logic                    wb_take;
	game_e                   game_q;
	logic [`MCR3_PORT_W-1:0] dip0_q;
	logic [`MCR3_PORT_W-1:0] dip1_q;
	logic [`MCR3_PORT_W-1:0] opt_q;

	// ==============================
	// Wishbone classic handshake
	// ==============================

	assign wb_open = wb_cyc & wb_stb;
	// No new acknowledge while the previous one is still up
	assign wb_take = wb_open & ~wb_ack;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wb_ack <= 1'b0;
			game_q <= GAME_RAMPAGE;
			dip0_q <= '0;
			dip1_q <= '0;
			opt_q  <= '0;
		end else begin
			wb_ack <= wb_take;
			if (wb_take && wb_we) begin
				case (wb_adr)
					`MCR3_ADR_GAME: game_q <= game_e'(wb_dat_w);
					`MCR3_ADR_DIP0: dip0_q <= wb_dat_w;
					`MCR3_ADR_DIP1: dip1_q <= wb_dat_w;
					default:        opt_q  <= wb_dat_w;
				endcase
			end
		end
	end

	// Read data lines up with the acknowledge
	always_ff @(posedge clk_sys) begin
		if (wb_take) begin
			case (wb_adr)
				`MCR3_ADR_GAME: wb_dat_r <= game_q;
				`MCR3_ADR_DIP0: wb_dat_r <= dip0_q;
				`MCR3_ADR_DIP1: wb_dat_r <= dip1_q;
				default:        wb_dat_r <= opt_q;
			endcase
		end
	end

	assign cfg.game       = game_q;
	assign cfg.dip0       = dip0_q;
	assign cfg.dip1       = dip1_q;
	assign cfg.twin_stick = opt_q[0];   // rest of the option byte is spare

endmodule

/* hw/input_port_mux.sv */
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

module input_port_mux (
	input  logic                         clk_sys,
	input  logic                         reset,
	mcr3_cfg_if.cfg_snk                  cfg,
	input  logic [`MCR3_CTRL_W-1:0]      joy1,
	input  logic [`MCR3_CTRL_W-1:0]      joy2,
	input  logic [`MCR3_CTRL_W-1:0]      joy3,
	input  logic [`MCR3_NUM_PLAYERS-1:0] gear,
	input  logic                         snd_stat,
	output logic [`MCR3_PORT_W-1:0]      input0,
	output logic [`MCR3_PORT_W-1:0]      input1,
	output logic [`MCR3_PORT_W-1:0]      input2,
	output logic [`MCR3_PORT_W-1:0]      input3,
	output logic [`MCR3_PORT_W-1:0]      input4
);
	import mcr3_input_pkg::*;

	logic                    any_coin;
	logic [`MCR3_PORT_W-1:0] act0;
	logic [`MCR3_PORT_W-1:0] act1;
	logic [`MCR3_PORT_W-1:0] act2;
	logic [`MCR3_PORT_W-1:0] act4;

	// Rampage player layout: B A L D R U
	function automatic logic [5:0] stick_and_buttons(input logic [`MCR3_CTRL_W-1:0] joy);
		return {joy[CTRL_FIRE_B], joy[CTRL_FIRE_A],
			joy[CTRL_LEFT], joy[CTRL_DOWN], joy[CTRL_RIGHT], joy[CTRL_UP]};
	endfunction

	// Sarge sticks as {right-down, right-up, left-down, left-up}
	// Twin mode folds one joystick into both tank treads
	function automatic logic [3:0] sarge_sticks(
		input logic [`MCR3_CTRL_W-1:0] joy,
		input logic                    twin
	);
		logic lu;
		logic ld;
		logic ru;
		logic rd;
		if (twin) begin
			lu = joy[CTRL_UP] | joy[CTRL_RIGHT];
			ld = joy[CTRL_DOWN] | joy[CTRL_LEFT];
			ru = joy[CTRL_UP] | joy[CTRL_LEFT];
			rd = joy[CTRL_DOWN] | joy[CTRL_RIGHT];
		end else begin
			lu = joy[CTRL_UP];
			ld = joy[CTRL_DOWN];
			ru = joy[CTRL_FIRE_C];
			rd = joy[CTRL_FIRE_B];
		end
		return {rd, ru, ld, lu};
	endfunction

	assign any_coin = joy1[CTRL_COIN] | joy2[CTRL_COIN] | joy3[CTRL_COIN];

	// ==============================
	// Per-game layout, active high
	// ==============================

	always_comb begin
		act0 = '0;
		act1 = '0;
		act2 = '0;
		act4 = '0;
		case (cfg.game)
			GAME_RAMPAGE: begin
				act0[0]   = any_coin;
				act0[5]   = cfg.dip1[0];
				act1[5:0] = stick_and_buttons(joy1);
				act2[5:0] = stick_and_buttons(joy2);
				act4[5:0] = stick_and_buttons(joy3);
				act4[7]   = snd_stat;
			end
			GAME_SARGE: begin
				act0[0] = any_coin;
				act0[2] = joy1[CTRL_START];
				act0[3] = joy2[CTRL_START];
				act0[5] = cfg.dip1[0];
				act1    = {joy1[CTRL_FIRE_D], joy1[CTRL_FIRE_D],
					joy1[CTRL_FIRE_A], joy1[CTRL_FIRE_A],
					sarge_sticks(joy1, cfg.twin_stick)};
				act2    = {joy2[CTRL_FIRE_D], joy2[CTRL_FIRE_D],
					joy2[CTRL_FIRE_A], joy2[CTRL_FIRE_A],
					sarge_sticks(joy2, cfg.twin_stick)};
			end
			GAME_POWERDRIVE: begin
				// Separate coin slot per player
				act0[0]   = joy1[CTRL_COIN];
				act0[1]   = joy2[CTRL_COIN];
				act0[2]   = joy3[CTRL_COIN];
				act0[5]   = cfg.dip1[0];
				act1      = {joy2[CTRL_FIRE_B], joy2[CTRL_FIRE_A], gear[1], joy2[CTRL_FIRE_C],
					joy1[CTRL_FIRE_B], joy1[CTRL_FIRE_A], gear[0], joy1[CTRL_FIRE_C]};
				act2[3:0] = {joy3[CTRL_FIRE_B], joy3[CTRL_FIRE_A], gear[2], joy3[CTRL_FIRE_C]};
				act2[7]   = snd_stat;
			end
			default: begin
				// Unmapped game, nothing pressed
				act0 = '0;
			end
		endcase
	end

	// Ports are active low, DIP byte goes out as stored
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			input0 <= `MCR3_PORT_IDLE;
			input1 <= `MCR3_PORT_IDLE;
			input2 <= `MCR3_PORT_IDLE;
			input3 <= `MCR3_PORT_IDLE;
			input4 <= `MCR3_PORT_IDLE;
		end else begin
			input0 <= ~act0;
			input1 <= ~act1;
			input2 <= ~act2;
			input3 <= cfg.dip0;
			input4 <= ~act4;
		end
	end

endmodule

/* hw/mcr3_cfg_if.sv */
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

// Board configuration from the register block to the mapper
interface mcr3_cfg_if;
	import mcr3_input_pkg::*;

	game_e                   game;
	logic [`MCR3_PORT_W-1:0] dip0;
	logic [`MCR3_PORT_W-1:0] dip1;
	// Option register bit 0
	logic                    twin_stick;

	modport cfg_src (
		output game, dip0, dip1, twin_stick
	);

	modport cfg_snk (
		input game, dip0, dip1, twin_stick
	);

endinterface

/* hw/mcr3_input_params.svh */
`ifndef MCR3_INPUT_PARAMS_SVH
`define MCR3_INPUT_PARAMS_SVH

// ==============================
// Widths
// ==============================

// CPU input port and every config register
`define MCR3_PORT_W 8

// Joystick word: R L D U, fire A to D, start, coin
`define MCR3_CTRL_W 10

`define MCR3_NUM_PLAYERS 3

// ==============================
// Register map
// ==============================

`define MCR3_ADR_W 2

`define MCR3_ADR_GAME 2'd0
`define MCR3_ADR_DIP0 2'd1
`define MCR3_ADR_DIP1 2'd2
`define MCR3_ADR_OPT  2'd3

// Port value with nothing pressed, inputs are active low
`define MCR3_PORT_IDLE 8'hFF

`endif

/* hw/mcr3_input_pkg.sv */
`include "mcr3_input_params.svh"

package mcr3_input_pkg;

	// Game select register values
	// Anything else leaves the ports idle
	typedef enum logic [`MCR3_PORT_W-1:0] {
		GAME_RAMPAGE    = 8'd0,
		GAME_SARGE      = 8'd1,
		GAME_POWERDRIVE = 8'd2
	} game_e;

	// Bit positions inside a joystick word
	typedef enum logic [3:0] {
		CTRL_RIGHT  = 4'd0,
		CTRL_LEFT   = 4'd1,
		CTRL_DOWN   = 4'd2,
		CTRL_UP     = 4'd3,
		CTRL_FIRE_A = 4'd4,
		CTRL_FIRE_B = 4'd5,
		CTRL_FIRE_C = 4'd6,
		CTRL_FIRE_D = 4'd7,
		CTRL_START  = 4'd8,
		CTRL_COIN   = 4'd9
	} ctrl_bit_e;

endpackage

/* hw/mcr3_input_top.sv */
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

module mcr3_input_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [`MCR3_ADR_W-1:0]  wb_adr,
	input  logic [`MCR3_PORT_W-1:0] wb_dat_w,
	output logic [`MCR3_PORT_W-1:0] wb_dat_r,
	output logic                    wb_ack,
	input  logic [`MCR3_CTRL_W-1:0] joy1,
	input  logic [`MCR3_CTRL_W-1:0] joy2,
	input  logic [`MCR3_CTRL_W-1:0] joy3,
	input  logic                    snd_stat,
	output logic [`MCR3_PORT_W-1:0] input0,
	output logic [`MCR3_PORT_W-1:0] input1,
	output logic [`MCR3_PORT_W-1:0] input2,
	output logic [`MCR3_PORT_W-1:0] input3,
	output logic [`MCR3_PORT_W-1:0] input4
);
	import mcr3_input_pkg::*;

	logic [`MCR3_NUM_PLAYERS-1:0] fire_d;
	logic [`MCR3_NUM_PLAYERS-1:0] gear;

	mcr3_cfg_if cfg_bus ();

	// Player 1 in bit 0
	assign fire_d = {joy3[CTRL_FIRE_D], joy2[CTRL_FIRE_D], joy1[CTRL_FIRE_D]};

	input_config_regs u_config_regs (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.cfg      (cfg_bus.cfg_src)
	);

	gear_shifter u_gear_shifter (
		.clk_sys (clk_sys),
		.reset   (reset),
		.fire_d  (fire_d),
		.gear    (gear)
	);

	input_port_mux u_port_mux (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cfg      (cfg_bus.cfg_snk),
		.joy1     (joy1),
		.joy2     (joy2),
		.joy3     (joy3),
		.gear     (gear),
		.snd_stat (snd_stat),
		.input0   (input0),
		.input1   (input1),
		.input2   (input2),
		.input3   (input3),
		.input4   (input4)
	);

endmodule

/* sources.f */
+incdir+hw
hw/mcr3_input_pkg.sv
hw/mcr3_cfg_if.sv
hw/input_config_regs.sv
hw/gear_shifter.sv
hw/input_port_mux.sv
hw/mcr3_input_top.sv
tb/mcr3_input_assertions.sv
tb/tb_mcr3_input.sv

/* tb/mcr3_input_assertions.sv */
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

module mcr3_input_assertions (
	input logic                    clk_sys,
	input logic                    reset,
	input logic                    wb_cyc,
	input logic                    wb_stb,
	input logic                    wb_ack,
	input logic [`MCR3_PORT_W-1:0] input3,
	input logic [`MCR3_PORT_W-1:0] dip0
);

	// Read by the testbench at the end of the run
	int unsigned fail_cnt = 0;

	// Acknowledge only answers an open cycle
	ack_after_open: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else begin
			$error("wb_ack without an open cycle before it");
			fail_cnt++;
		end

	ack_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		wb_ack |=> !wb_ack)
		else begin
			$error("wb_ack high for two cycles");
			fail_cnt++;
		end

	// DIP byte 0 passes straight through the port register
	dip0_on_input3: assert property (@(posedge clk_sys)
		!reset |=> (input3 == $past(dip0)))
		else begin
			$error("input3 does not follow dip0");
			fail_cnt++;
		end

endmodule

bind mcr3_input_top mcr3_input_assertions u_assert (
	.clk_sys (clk_sys),
	.reset   (reset),
	.wb_cyc  (wb_cyc),
	.wb_stb  (wb_stb),
	.wb_ack  (wb_ack),
	.input3  (input3),
	.dip0    (cfg_bus.dip0)
);

/* tb/tb_mcr3_input.sv */
`timescale 1ns/1ps
`include "mcr3_input_params.svh"

module tb_mcr3_input;
	import mcr3_input_pkg::*;

	logic                    clk_sys;
	logic                    reset;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	logic [`MCR3_ADR_W-1:0]  wb_adr;
	logic [`MCR3_PORT_W-1:0] wb_dat_w;
	logic [`MCR3_PORT_W-1:0] wb_dat_r;
	logic                    wb_ack;
	logic [`MCR3_CTRL_W-1:0] joy1;
	logic [`MCR3_CTRL_W-1:0] joy2;
	logic [`MCR3_CTRL_W-1:0] joy3;
	logic                    snd_stat;
	logic [`MCR3_PORT_W-1:0] input0;
	logic [`MCR3_PORT_W-1:0] input1;
	logic [`MCR3_PORT_W-1:0] input2;
	logic [`MCR3_PORT_W-1:0] input3;
	logic [`MCR3_PORT_W-1:0] input4;

	// Register contents and gears as the testbench expects them
	logic [7:0]  regs_model [4];
	logic [2:0]  gear_model;
	logic [39:0] exp_ports;
	int          stim_cnt = 0;
	int          seen_cnt = 0;
	int          settle = 0;
	int          wb_errors = 0;
	int          wb_checks = 0;
	int          port_errors = 0;
	int          port_checks = 0;
	int          errors_before = 0;

	mcr3_input_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp,
		inout int errs, inout int cnt);
		cnt++;
		assert (got === exp) else begin
			$display("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp);
			errs++;
		end
	endtask

	// ==============================
	// Reference model
	// ==============================

	// Rampage player bits up, right, down, left, fire A and fire B from bit 0
	function automatic logic [7:0] rampage_player(input logic [9:0] j);
		logic [7:0] p;
		p = '0;
		p[0] = j[CTRL_UP];
		p[1] = j[CTRL_RIGHT];
		p[2] = j[CTRL_DOWN];
		p[3] = j[CTRL_LEFT];
		p[4] = j[CTRL_FIRE_A];
		p[5] = j[CTRL_FIRE_B];
		return p;
	endfunction

	function automatic logic [7:0] sarge_player(input logic [9:0] j, input logic twin);
		logic [7:0] p;
		p = '0;
		if (twin) begin
			p[0] = j[CTRL_UP] | j[CTRL_RIGHT];
			p[1] = j[CTRL_DOWN] | j[CTRL_LEFT];
			p[2] = j[CTRL_UP] | j[CTRL_LEFT];
			p[3] = j[CTRL_DOWN] | j[CTRL_RIGHT];
		end else begin
			p[0] = j[CTRL_UP];
			p[1] = j[CTRL_DOWN];
			p[2] = j[CTRL_FIRE_C];
			p[3] = j[CTRL_FIRE_B];
		end
		p[4] = j[CTRL_FIRE_A];
		p[5] = j[CTRL_FIRE_A];
		p[6] = j[CTRL_FIRE_D];
		p[7] = j[CTRL_FIRE_D];
		return p;
	endfunction

	// Returns {input4, input3, input2, input1, input0}
	function automatic logic [39:0] expected_ports(
		input logic [7:0] game,
		input logic [7:0] dip0,
		input logic [7:0] dip1,
		input logic       twin,
		input logic [9:0] j1,
		input logic [9:0] j2,
		input logic [9:0] j3,
		input logic [2:0] gr,
		input logic       snd
	);
		logic [7:0] p0;
		logic [7:0] p1;
		logic [7:0] p2;
		logic [7:0] p4;
		logic       coin;
		p0 = '0;
		p1 = '0;
		p2 = '0;
		p4 = '0;
		coin = j1[CTRL_COIN] | j2[CTRL_COIN] | j3[CTRL_COIN];
		if (game == GAME_RAMPAGE) begin
			p0[0] = coin;
			p1 = rampage_player(j1);
			p2 = rampage_player(j2);
			p4 = rampage_player(j3);
			p4[7] = snd;
		end else if (game == GAME_SARGE) begin
			p0[0] = coin;
			p0[2] = j1[CTRL_START];
			p0[3] = j2[CTRL_START];
			p1 = sarge_player(j1, twin);
			p2 = sarge_player(j2, twin);
		end else if (game == GAME_POWERDRIVE) begin
			p0[0] = j1[CTRL_COIN];
			p0[1] = j2[CTRL_COIN];
			p0[2] = j3[CTRL_COIN];
			p1[0] = j1[CTRL_FIRE_C];
			p1[1] = gr[0];
			p1[2] = j1[CTRL_FIRE_A];
			p1[3] = j1[CTRL_FIRE_B];
			p1[4] = j2[CTRL_FIRE_C];
			p1[5] = gr[1];
			p1[6] = j2[CTRL_FIRE_A];
			p1[7] = j2[CTRL_FIRE_B];
			p2[0] = j3[CTRL_FIRE_C];
			p2[1] = gr[2];
			p2[2] = j3[CTRL_FIRE_A];
			p2[3] = j3[CTRL_FIRE_B];
			p2[7] = snd;
		end
		if (game <= 8'd2)
			p0[5] = dip1[0];
		return {~p4, dip0, ~p2, ~p1, ~p0};
	endfunction

	// Ports settle two rising edges after a stimulus change
	always @(negedge clk_sys) begin
		if (stim_cnt != seen_cnt) begin
			seen_cnt = stim_cnt;
			settle = 2;
		end else if (settle != 0) begin
			settle--;
			if (settle == 0) begin
				exp_ports = expected_ports(regs_model[`MCR3_ADR_GAME], regs_model[`MCR3_ADR_DIP0],
					regs_model[`MCR3_ADR_DIP1], regs_model[`MCR3_ADR_OPT][0],
					joy1, joy2, joy3, gear_model, snd_stat);
				check_byte("input0", input0, exp_ports[7:0], port_errors, port_checks);
				check_byte("input1", input1, exp_ports[15:8], port_errors, port_checks);
				check_byte("input2", input2, exp_ports[23:16], port_errors, port_checks);
				check_byte("input3", input3, exp_ports[31:24], port_errors, port_checks);
				check_byte("input4", input4, exp_ports[39:32], port_errors, port_checks);
			end
		end
	end

	// ==============================
	// Stimulus tasks
	// ==============================

	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [7:0] wdata,
		output logic [7:0] rdata);
		int n;
		n = 0;
		rdata = '0;
		@(posedge clk_sys);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		do begin
			@(posedge clk_sys);
			#1;
			n++;
		end while (!wb_ack && n < 16);
		if (!wb_ack) begin
			$display("Timeout: register %0d access got no acknowledge", adr);
			wb_errors++;
		end else begin
			wb_checks++;
			assert (n == 1) else begin
				$display("** Error: wb_ack latency = 0x%0h, expected 0x1", n);
				wb_errors++;
			end
			rdata = wb_dat_r;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// Strobe held through the acknowledge gives one acknowledge every second cycle
	task automatic read_with_held_strobe(input logic [1:0] adr, input logic [7:0] exp);
		int   beat;
		int   acks;
		logic exp_ack;
		beat = 0;
		acks = 0;
		@(posedge clk_sys);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		while (acks < 3 && beat < 16) begin
			@(posedge clk_sys);
			#1;
			beat++;
			exp_ack = beat[0];
			wb_checks++;
			assert (wb_ack === exp_ack) else begin
				$display("** Error: wb_ack = 0x%0h, expected 0x%0h", wb_ack, exp_ack);
				wb_errors++;
			end
			if (wb_ack) begin
				acks++;
				check_byte("wb_dat_r", wb_dat_r, exp, wb_errors, wb_checks);
			end
		end
		if (acks < 3) begin
			$display("Timeout: held strobe read of register %0d got too few acknowledges", adr);
			wb_errors++;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [7:0] data);
		logic [7:0] rd;
		wb_access(1'b1, adr, data, rd);
		regs_model[adr] = data;
	endtask

	task automatic read_check(input logic [1:0] adr, input logic [7:0] exp);
		logic [7:0] rd;
		wb_access(1'b0, adr, 8'h00, rd);
		check_byte("wb_dat_r", rd, exp, wb_errors, wb_checks);
	endtask

	// Hold each input set long enough for the comparer to sample it
	task automatic apply_inputs(input logic [9:0] j1, input logic [9:0] j2,
		input logic [9:0] j3, input logic snd);
		logic [2:0] fd_old;
		logic [2:0] fd_new;
		fd_old = {joy3[CTRL_FIRE_D], joy2[CTRL_FIRE_D], joy1[CTRL_FIRE_D]};
		fd_new = {j3[CTRL_FIRE_D], j2[CTRL_FIRE_D], j1[CTRL_FIRE_D]};
		@(posedge clk_sys);
		#1;
		gear_model = gear_model ^ (fd_new & ~fd_old);
		joy1 = j1;
		joy2 = j2;
		joy3 = j3;
		snd_stat = snd;
		stim_cnt++;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic apply_random();
		apply_inputs(10'($urandom()), 10'($urandom()), 10'($urandom()), 1'($urandom()));
	endtask

	task automatic apply_fire_d(input logic [2:0] fd);
		logic [9:0] j1;
		logic [9:0] j2;
		logic [9:0] j3;
		j1 = 10'($urandom());
		j2 = 10'($urandom());
		j3 = 10'($urandom());
		j1[CTRL_FIRE_D] = fd[0];
		j2[CTRL_FIRE_D] = fd[1];
		j3[CTRL_FIRE_D] = fd[2];
		apply_inputs(j1, j2, j3, 1'($urandom()));
	endtask

	task automatic end_test(input string name);
		int now;
		now = wb_errors + port_errors;
		$display("%-18s %0d errors", name, now - errors_before);
		errors_before = now;
	endtask

	initial begin
		logic [7:0] rnd [4];
		int         total;
		void'($urandom(6154));
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		joy1 = '0;
		joy2 = '0;
		joy3 = '0;
		snd_stat = 1'b0;
		gear_model = '0;
		for (int a = 0; a < 4; a++)
			regs_model[a] = '0;
		repeat (10) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		check_byte("input0", input0, 8'hFF, wb_errors, wb_checks);
		check_byte("input1", input1, 8'hFF, wb_errors, wb_checks);
		check_byte("input2", input2, 8'hFF, wb_errors, wb_checks);
		check_byte("input3", input3, 8'hFF, wb_errors, wb_checks);
		check_byte("input4", input4, 8'hFF, wb_errors, wb_checks);
		for (int a = 0; a < 4; a++)
			read_check(2'(a), 8'h00);
		end_test("reset values");

		for (int a = 0; a < 4; a++) begin
			rnd[a] = 8'($urandom());
			write_reg(2'(a), rnd[a]);
		end
		for (int a = 0; a < 4; a++)
			read_check(2'(a), rnd[a]);
		read_with_held_strobe(`MCR3_ADR_DIP1, rnd[2]);
		end_test("register access");

		write_reg(`MCR3_ADR_GAME, GAME_RAMPAGE);
		write_reg(`MCR3_ADR_DIP0, 8'($urandom()));
		write_reg(`MCR3_ADR_DIP1, 8'($urandom()));
		repeat (20) apply_random();
		end_test("rampage");

		write_reg(`MCR3_ADR_GAME, GAME_SARGE);
		write_reg(`MCR3_ADR_OPT, 8'h01);
		repeat (15) apply_random();
		write_reg(`MCR3_ADR_OPT, 8'h00);
		repeat (15) apply_random();
		end_test("sarge");

		write_reg(`MCR3_ADR_GAME, GAME_POWERDRIVE);
		repeat (24) apply_fire_d(3'($urandom()));
		end_test("power drive");

		write_reg(`MCR3_ADR_GAME, 8'($urandom_range(255, 3)));
		write_reg(`MCR3_ADR_DIP0, 8'($urandom()));
		repeat (8) apply_random();
		end_test("unmapped game");

		total = wb_errors + port_errors + int'(dut.u_assert.fail_cnt);
		$display("Checks %0d, errors %0d, assertion failures %0d",
			wb_checks + port_checks, wb_errors + port_errors, dut.u_assert.fail_cnt);
		if (total == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
